// ==== src.f ====
+incdir+common
common/sidPkg.sv
hw/clipper.sv
hw/mult/sidMultipliers.sv
hw/voiceMixer.sv
hw/filter/voiceFilter.sv
hw/sidAudioPath.sv
verification/tbSidAudioPath.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tbSidAudioPath
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/tbSidAudioPath.sv ====
// directed tests; mode, coef and volume only change while no sample is in flight
`timescale 1ns/1ps
`include "sid_config.svh"

module tbSidAudioPath;

  localparam int resetCycles  = 8;
  localparam int drainLen     = 6;  // longer than the 3-cycle latency
  localparam int testCycles   = resetCycles + 8 + 1 + 54 + 4 + 2 + 60 + 40 + 8 * drainLen;
  localparam int timeoutLimit = testCycles + `SID_TIMEOUT_MARGIN;

  logic                   clk;
  logic                   rst;
  logic                   sampleValid;
  sidPkg::voice_t         voice0, voice1, voice2;
  logic [7:0]             env0, env1, env2;
  logic [`SID_VOICES-1:0] filterRoute;
  sidPkg::filterMode_t    mode;
  logic [15:0]            coef;
  logic [3:0]             volume;
  sidPkg::sample_t        audioOut;
  logic                   audioValid;

  int              mismatches;
  int              otherErrors;
  int              cycleCount;
  string           curTest;
  logic [31:0]     lfsr;
  longint          modelLp;      // model filter state
  sidPkg::sample_t expQ[$];      // expected outputs in strobe order
  logic [2:0]      validHist;    // strobe seen at the last three edges
  logic            riseCheck;    // step test watches for a falling output
  sidPkg::sample_t lastOut;

  sidAudioPath dut0 (
    .clk(clk), .rst(rst), .sampleValid(sampleValid),
    .voice0(voice0), .voice1(voice1), .voice2(voice2),
    .env0(env0), .env1(env1), .env2(env2), .filterRoute(filterRoute),
    .mode(mode), .coef(coef), .volume(volume),
    .audioOut(audioOut), .audioValid(audioValid)
  );

  always #20 clk = ~clk;  // 40 ns period

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic sidPkg::sample_t clip16(input longint x);
    return (x > 32767) ? 16'sh7fff : (x < -32768) ? 16'sh8000 : sidPkg::sample_t'(x);
  endfunction

  function automatic longint sat17(input longint x);
    return (x > 65535) ? 65535 : (x < -65536) ? -65536 : x;
  endfunction

  // reference model for the sample now on the inputs
  task automatic predict();
    sidPkg::voice_t v [3];
    logic [7:0]     e [3];
    longint         filtSum;
    longint         directSum;
    longint         diffV;
    longint         lpNext;
    longint         outV;
    longint         mixV;
    v = '{voice0, voice1, voice2};
    e = '{env0, env1, env2};
    filtSum   = 0;
    directSum = 0;
    for (int i = 0; i < 3; i++) begin
      if (filterRoute[i]) filtSum += (longint'(v[i]) * longint'(e[i])) >>> 4;  // voice*env/16
      else directSum += (longint'(v[i]) * longint'(e[i])) >>> 4;
    end
    filtSum   = sat17(filtSum);
    directSum = sat17(directSum);
    diffV     = clip16(filtSum - modelLp);
    lpNext    = clip16(modelLp + ((diffV * longint'(coef)) >>> 16));  // top half of product
    case (mode)
      sidPkg::modeLowpass:  outV = lpNext;
      sidPkg::modeHighpass: outV = diffV;
      default:              outV = clip16(filtSum);
    endcase
    modelLp = lpNext;  // state moves in every mode
    mixV    = clip16(outV + directSum);
    expQ.push_back(sidPkg::sample_t'((mixV * longint'(volume)) >>> 4));
  endtask

  task automatic compareSample(input string name, input sidPkg::sample_t expected,
                               input sidPkg::sample_t actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic compareValid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch %s audioValid: expected %0b, actual %0b", name, expected, actual);
    end
  endtask

  // drive one strobe, leaves sampleValid high for back-to-back use
  task automatic sendSample(input sidPkg::voice_t v0, input sidPkg::voice_t v1,
                            input sidPkg::voice_t v2, input logic [7:0] e0,
                            input logic [7:0] e1, input logic [7:0] e2,
                            input logic [`SID_VOICES-1:0] route);
    voice0      = v0;
    voice1      = v1;
    voice2      = v2;
    env0        = e0;
    env1        = e1;
    env2        = e2;
    filterRoute = route;
    sampleValid = 1'b1;
    predict();
    @(negedge clk);
  endtask

  task automatic drain();
    sampleValid = 1'b0;
    repeat (drainLen) @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (rst) validHist <= '0;
    else validHist <= {validHist[1:0], sampleValid};
    if (cycleCount > timeoutLimit) begin
      $display("timeout after %0d cycles, tests did not finish", cycleCount);
      $display("test failed");
      $finish;
    end
  end

  // outputs settled since the rising edge
  always @(negedge clk) begin : checkOutputs
    sidPkg::sample_t expected;
    compareValid(curTest, validHist[2], audioValid);
    if (validHist[2]) begin
      if (expQ.size() == 0) begin
        otherErrors++;
        $display("%s: output strobe with no sample pending", curTest);
      end else begin
        expected = expQ.pop_front();
        compareSample(curTest, expected, audioOut);
        if (riseCheck && audioOut < lastOut) begin
          otherErrors++;
          $display("%s: output fell from %0d to %0d", curTest, lastOut, audioOut);
        end
        lastOut = audioOut;
      end
    end
  end

  task automatic testIdleAndLatency();
    curTest = "idle";
    repeat (8) begin
      compareSample(curTest, 16'sd0, audioOut);  // zero until first strobe
      @(negedge clk);
    end
    curTest = "latency";
    sendSample(12'sd100, 12'sd0, 12'sd0, 8'd200, 8'd0, 8'd0, 3'b000);
    drain();
  endtask

  task automatic testEnvelopeVolume();
    logic [3:0]     vols [3];
    logic [7:0]     envs [3];
    sidPkg::voice_t lvls [2];
    vols    = '{4'd15, 4'd8, 4'd1};
    envs    = '{8'd255, 8'd128, 8'd17};
    lvls    = '{12'sd1234, -12'sd2048};
    curTest = "envelope and volume";
    for (int vi = 0; vi < 3; vi++) begin
      volume = vols[vi];  // pipeline empty here
      for (int ei = 0; ei < 3; ei++)
        for (int v = 0; v < 3; v++)
          for (int li = 0; li < 2; li++)
            sendSample(v == 0 ? lvls[li] : 12'sd0, v == 1 ? lvls[li] : 12'sd0,
                       v == 2 ? lvls[li] : 12'sd0, v == 0 ? envs[ei] : 8'd0,
                       v == 1 ? envs[ei] : 8'd0, v == 2 ? envs[ei] : 8'd0,
                       `SID_VOICES'(randBits(`SID_VOICES)));
      drain();
    end
  endtask

  task automatic testSaturation();
    curTest = "saturation";
    volume  = 4'd15;
    sendSample(12'sd2047, 12'sd2047, 12'sd2047, 8'd255, 8'd255, 8'd255, 3'b111);
    sendSample(12'sd2047, 12'sd2047, 12'sd2047, 8'd255, 8'd255, 8'd255, 3'b000);
    sendSample(-12'sd2048, -12'sd2048, -12'sd2048, 8'd255, 8'd255, 8'd255, 3'b111);
    sendSample(-12'sd2048, -12'sd2048, -12'sd2048, 8'd255, 8'd255, 8'd255, 3'b000);
    drain();
  endtask

  task automatic testLowpassStep();
    curTest = "lowpass step";
    rst     = 1'b1;  // clear the filter state
    repeat (2) @(negedge clk);
    rst       = 1'b0;
    modelLp   = 0;
    mode      = sidPkg::modeLowpass;
    coef      = `SID_COEF_RESET;
    lastOut   = 16'sh8000;
    riseCheck = 1'b1;
    repeat (60) sendSample(12'sd2000, 12'sd0, 12'sd0, 8'd255, 8'd0, 8'd0, 3'b001);
    drain();
    riseCheck = 1'b0;
    if (lastOut <= 0) begin
      otherErrors++;
      $display("lowpass step: output never rose above zero");
    end
  endtask

  task automatic testHighpassRouting();
    curTest = "highpass routing";
    mode    = sidPkg::modeHighpass;
    coef    = 16'(randBits(16));
    volume  = 4'd8 | 4'(randBits(3));  // upper half, never silent
    repeat (40)
      sendSample(sidPkg::voice_t'(randBits(12)), sidPkg::voice_t'(randBits(12)),
                 sidPkg::voice_t'(randBits(12)), 8'(randBits(8)), 8'(randBits(8)),
                 8'(randBits(8)), `SID_VOICES'(randBits(`SID_VOICES)));
    drain();
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    sampleValid = 1'b0;
    voice0      = '0;
    voice1      = '0;
    voice2      = '0;
    env0        = '0;
    env1        = '0;
    env2        = '0;
    filterRoute = '0;
    mode        = sidPkg::modeBypass;
    coef        = `SID_COEF_RESET;
    volume      = 4'd15;
    lfsr        = 32'h5ce531ee;
    mismatches  = 0;
    otherErrors = 0;
    cycleCount  = 0;
    modelLp     = 0;
    riseCheck   = 1'b0;
    lastOut     = '0;
    curTest     = "reset";
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;
    testIdleAndLatency();
    testEnvelopeVolume();
    testSaturation();
    testLowpassStep();
    testHighpassRouting();
    if (expQ.size() != 0) begin
      otherErrors++;
      $display("%0d expected samples never came out", expQ.size());
    end
    $display("errors: %0d mismatches, %0d other", mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== hw/sidAudioPath.sv ====
// audioValid is a 1-cycle strobe 3 cycles after sampleValid; mode, coef and volume are static
`timescale 1ns/1ps
`include "sid_config.svh"

module sidAudioPath (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sampleValid,
  input  sidPkg::voice_t         voice0,
  input  sidPkg::voice_t         voice1,
  input  sidPkg::voice_t         voice2,
  input  logic [7:0]             env0,
  input  logic [7:0]             env1,
  input  logic [7:0]             env2,
  input  logic [`SID_VOICES-1:0] filterRoute,
  input  sidPkg::filterMode_t    mode,
  input  logic [15:0]            coef,
  input  logic [3:0]             volume,
  output sidPkg::sample_t        audioOut,
  output logic                   audioValid
);

  sidPkg::wide_t      filtIn;     // mixer to filter
  sidPkg::wide_t      directSum;
  logic               mixValid;
  sidPkg::sample_t    filtOut;    // filter stage outputs
  sidPkg::wide_t      directOut;
  logic               filtValid;
  logic signed [17:0] finalFull;  // filtered plus direct
  sidPkg::wide_t      finalWide;
  sidPkg::sample_t    finalMix;   // into the volume stage

  voiceMixer mixer0 (
    .clk(clk), .rst(rst), .sampleValid(sampleValid),
    .voice0(voice0), .voice1(voice1), .voice2(voice2),
    .env0(env0), .env1(env1), .env2(env2), .filterRoute(filterRoute),
    .filtIn(filtIn), .directSum(directSum), .mixValid(mixValid)
  );

  voiceFilter filter0 (
    .clk(clk), .rst(rst), .mixValid(mixValid), .filtIn(filtIn),
    .directSum(directSum), .mode(mode), .coef(coef),
    .filtOut(filtOut), .directOut(directOut), .filtValid(filtValid)
  );

  assign finalFull = {{2{filtOut[15]}}, filtOut} + {directOut[16], directOut};
  assign finalWide = sidPkg::satWide(finalFull);

  clipper clipMix (
    .in (finalWide),
    .out(finalMix)
  );

  mdac16x4 volume0 (
    .clk  (clk),
    .voice(finalMix),
    .vol  (volume),
    .out  (audioOut)  // zero after reset since the filter outputs are cleared
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      audioValid <= 1'b0;
    end else begin
      audioValid <= filtValid;  // matches the mdac16x4 register
    end
  end

endmodule

// ==== hw/filter/voiceFilter.sv ====
// one-pole filter, coef in 0..65535 sets the pole; state only moves on mixValid, even in bypass
`timescale 1ns/1ps

module voiceFilter (
  input  logic                clk,
  input  logic                rst,
  input  logic                mixValid,
  input  sidPkg::wide_t       filtIn,
  input  sidPkg::wide_t       directSum,
  input  sidPkg::filterMode_t mode,
  input  logic [15:0]         coef,
  output sidPkg::sample_t     filtOut,
  output sidPkg::wide_t       directOut,
  output logic                filtValid
);

  sidPkg::sample_t    lp;        // lowpass state
  logic signed [17:0] diffFull;  // input minus state, full width
  sidPkg::wide_t      diffWide;  // limited to 17 bits
  sidPkg::sample_t    diff;      // highpass value
  sidPkg::sample_t    multOut;   // coef * diff
  sidPkg::wide_t      lpSum;     // state plus step
  sidPkg::sample_t    lpNext;    // saturated new state
  sidPkg::sample_t    inClip;    // bypass value
  sidPkg::sample_t    selOut;    // mode-selected output

  assign diffFull = {filtIn[16], filtIn} - {{2{lp[15]}}, lp};
  assign diffWide = sidPkg::satWide(diffFull);

  clipper clipDiff (
    .in (diffWide),
    .out(diff)
  );

  mult16x16 mult0 (
    .signal(diffWide),  // clipped again inside, same as diff
    .coef  (coef),
    .out   (multOut)
  );

  assign lpSum = {lp[15], lp} + {multOut[15], multOut};

  // keeps the state in range when the input runs past 16 bits
  clipper clipState (
    .in (lpSum),
    .out(lpNext)
  );

  clipper clipIn (
    .in (filtIn),
    .out(inClip)
  );

  always_comb begin
    case (mode)
      sidPkg::modeLowpass:  selOut = lpNext;
      sidPkg::modeHighpass: selOut = diff;
      default:              selOut = inClip;  // bypass
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lp        <= '0;
      filtOut   <= '0;
      directOut <= '0;
      filtValid <= 1'b0;
    end else begin
      filtValid <= mixValid;
      if (mixValid) begin
        lp        <= lpNext;
        filtOut   <= selOut;
        directOut <= directSum;  // kept in step with filtOut
      end
    end
  end

  // mode comes straight from the top level pins
  assert property (@(posedge clk) disable iff (rst)
    mixValid |-> (mode inside {sidPkg::modeBypass, sidPkg::modeLowpass, sidPkg::modeHighpass}))
    else $error("illegal filter mode %0d", mode);

endmodule

// ==== hw/voiceMixer.sv ====
// route bit 1 sends a voice to the filter; all inputs are sampled with sampleValid
`timescale 1ns/1ps
`include "sid_config.svh"

module voiceMixer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sampleValid,
  input  sidPkg::voice_t         voice0,
  input  sidPkg::voice_t         voice1,
  input  sidPkg::voice_t         voice2,
  input  logic [7:0]             env0,
  input  logic [7:0]             env1,
  input  logic [7:0]             env2,
  input  logic [`SID_VOICES-1:0] filterRoute,
  output sidPkg::wide_t          filtIn,
  output sidPkg::wide_t          directSum,
  output logic                   mixValid
);

  sidPkg::voice_t         voiceArr [`SID_VOICES];  // voices as an array
  logic [7:0]             envArr   [`SID_VOICES];
  sidPkg::sample_t        scaled   [`SID_VOICES];  // registered in the mdacs
  logic [`SID_VOICES-1:0] routeReg;                // aligned with scaled
  logic signed [17:0]     filtAcc;                 // room for three full-scale terms
  logic signed [17:0]     directAcc;

  assign voiceArr = '{voice0, voice1, voice2};
  assign envArr   = '{env0, env1, env2};

  for (genvar i = 0; i < `SID_VOICES; i++) begin : gMdac
    mdac12x8 mdac (
      .clk  (clk),
      .voice(voiceArr[i]),
      .env  (envArr[i]),
      .out  (scaled[i])
    );
  end

  always_ff @(posedge clk) begin
    routeReg <= filterRoute;  // same stage as the mdac registers
    if (rst) begin
      mixValid <= 1'b0;
    end else begin
      mixValid <= sampleValid;
    end
  end

  always_comb begin
    filtAcc   = '0;
    directAcc = '0;
    for (int i = 0; i < `SID_VOICES; i++) begin
      if (routeReg[i]) begin
        filtAcc = filtAcc + 18'(scaled[i]);  // sign-extended
      end else begin
        directAcc = directAcc + 18'(scaled[i]);
      end
    end
  end

  assign filtIn    = sidPkg::satWide(filtAcc);
  assign directSum = sidPkg::satWide(directAcc);

endmodule

// ==== hw/mult/sidMultipliers.sv ====
// inferred stand-ins for the MAC16 multipliers; mult16x16 is unregistered, the mdacs have one stage
`timescale 1ns/1ps

// filter multiplier, signed signal times unsigned coefficient
module mult16x16 (
  input  sidPkg::wide_t   signal,
  input  logic [15:0]     coef,
  output sidPkg::sample_t out
);

  sidPkg::sample_t    clipped;  // signal limited to 16 bits
  logic signed [32:0] product;  // 16 x 17 signed, coef zero-extended

  clipper clip0 (
    .in (signal),
    .out(clipped)
  );

  assign product = clipped * $signed({1'b0, coef});  // unsigned coef
  assign out     = product[31:16];                   // top half of the 32-bit product

endmodule

// master volume, 16-bit sample times 4-bit unsigned level
module mdac16x4 (
  input  logic            clk,
  input  sidPkg::sample_t voice,
  input  logic [3:0]      vol,
  output sidPkg::sample_t out
);

  logic signed [31:0] product;  // fits in 20 bits

  // magnitude in a wider type so -32768 stays positive
  function automatic int absVal(input sidPkg::sample_t v);
    int wide;
    wide = int'(v);
    absVal = (wide < 0) ? -wide : wide;
  endfunction

  assign product = voice * $signed({1'b0, vol});

  always_ff @(posedge clk) begin
    out <= product[19:4];  // divide by 16
  end

  // full volume is 15/16, so the output never grows
  assert property (@(posedge clk)
    (vol == 4'hf) |=> (absVal(out) <= absVal($past(voice))))
    else $error("mdac16x4 output larger than input at full volume");

endmodule

// envelope scaling, 12-bit voice times 8-bit unsigned envelope
module mdac12x8 (
  input  logic            clk,
  input  sidPkg::voice_t  voice,
  input  logic [7:0]      env,
  output sidPkg::sample_t out
);

  logic signed [15:0] voiceHigh;  // voice in the top 12 bits
  logic signed [31:0] product;    // fits in 24 bits

  assign voiceHigh = {voice, 4'b0000};
  assign product   = voiceHigh * $signed({1'b0, env});  // unsigned env

  always_ff @(posedge clk) begin
    out <= product[23:8];  // voice * env >>> 4
  end

endmodule

// ==== hw/clipper.sv ====
// purely combinational 17-to-16-bit saturation, no rounding
`timescale 1ns/1ps

module clipper (
  input  sidPkg::wide_t   in,
  output sidPkg::sample_t out
);

  logic overflow;  // top two bits disagree

  assign overflow = in[16] ^ in[15];

  always_comb begin
    if (overflow) begin
      if (in[16]) begin
        out = 16'sh8000;  // below -32768
      end else begin
        out = 16'sh7fff;  // above 32767
      end
    end else begin
      out = in[15:0];  // already in range
    end
  end

endmodule

// ==== common/sidPkg.sv ====
// audio back end types; satWide assumes sums of at most four 16-bit terms (18-bit input)
package sidPkg;

  typedef enum logic [1:0] {
    modeBypass   = 2'd0,  // clipped input straight through
    modeLowpass  = 2'd1,  // one-pole state
    modeHighpass = 2'd2   // input minus state
  } filterMode_t;

  typedef logic signed [15:0] sample_t;  // audio sample
  typedef logic signed [16:0] wide_t;    // pre-clip sum
  typedef logic signed [11:0] voice_t;   // raw waveform

  // saturate an 18-bit sum to the 17-bit range
  function automatic wide_t satWide(input logic signed [17:0] x);
    if (x[17] != x[16]) begin
      satWide = x[17] ? 17'h10000 : 17'h0ffff;  // most negative / most positive
    end else begin
      satWide = x[16:0];
    end
  endfunction

endpackage

// ==== common/sid_config.svh ====
// build-wide constants; SID_VOICES above 4 would overflow the 18-bit mixer accumulators
`ifndef SID_CONFIG_SVH
`define SID_CONFIG_SVH

// number of voices, one routing bit each
`define SID_VOICES 3

// filter coefficient loaded after reset, about 1/32 of full scale
`define SID_COEF_RESET 16'h0800

// extra cycles granted to the testbench before it gives up
`define SID_TIMEOUT_MARGIN 200

`endif
